//--- verilog/ctrl_macros.svh
`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

// instruction field widths
`define OPCODE_W 6
`define FUNCT_W 6

// step counter inside one phase
`define STEP_W 2

// fixed phase lengths in cycles
`define FETCH_STEPS 3
`define DECODE_STEPS 3

`endif

//--- verilog/isaPkg.sv
`include "ctrl_macros.svh"

package isaPkg;

    // primary opcode, only R-type is decoded
    typedef enum logic [`OPCODE_W-1:0] {
        RTYPE = `OPCODE_W'd0
    } opcode_e;

    // R-type function codes handled by the unit
    typedef enum logic [`FUNCT_W-1:0] {
        FN_JR    = `FUNCT_W'd8,
        FN_BREAK = `FUNCT_W'd13,
        FN_RTE   = `FUNCT_W'd19,
        FN_ADD   = `FUNCT_W'd32,
        FN_SUB   = `FUNCT_W'd34,
        FN_AND   = `FUNCT_W'd36,
        FN_SLT   = `FUNCT_W'd42
    } funct_e;

    // decoded instruction class
    typedef enum logic [2:0] {
        ICL_ADD,
        ICL_SUB,
        ICL_AND,
        ICL_SLT,
        ICL_JR,
        ICL_BREAK,
        ICL_RTE,
        ICL_ILLEGAL
    } instrClass_e;

endpackage

//--- verilog/ctrlPkg.sv
package ctrlPkg;

    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_SLT  = 3'd7
    } aluOp_e;

    typedef enum logic [1:0] {
        SRCA_PC   = 2'd0,
        SRCA_REGA = 2'd2
    } aluSrcA_e;

    typedef enum logic [1:0] {
        SRCB_REGB = 2'd0,
        SRCB_FOUR = 2'd1
    } aluSrcB_e;

    typedef enum logic [2:0] {
        PCSRC_ALU = 3'd0,
        PCSRC_EPC = 3'd5
    } pcSrc_e;

    // instruction phases, execute phases one per class
    typedef enum logic [3:0] {
        PH_FETCH,
        PH_IRLOAD,
        PH_DECODE,
        PH_ADD,
        PH_SUB,
        PH_AND,
        PH_SLT,
        PH_JR,
        PH_BREAK,
        PH_RTE
    } phase_e;

    // one cycle of datapath control, 24 bits
    typedef struct packed {
        logic       pcWrite;
        logic       memRead;
        logic       irWrite;
        logic       regWrite;
        logic       aluOutWrite;
        aluSrcA_e   aluSrcA;
        aluSrcB_e   aluSrcB;
        logic [1:0] regDst;
        logic [2:0] addrSel;
        aluOp_e     aluOp;
        pcSrc_e     pcSrc;
        logic [3:0] writeDataSel;
    } ctrlWord_t;

    localparam ctrlWord_t IDLE_WORD = '{
        pcWrite: 1'b0, memRead: 1'b0, irWrite: 1'b0, regWrite: 1'b0,
        aluOutWrite: 1'b0, aluSrcA: SRCA_PC, aluSrcB: SRCB_REGB,
        regDst: 2'd0, addrSel: 3'd0, aluOp: ALU_PASS, pcSrc: PCSRC_ALU,
        writeDataSel: 4'd0
    };

    // word held on the datapath while reset is asserted
    localparam ctrlWord_t RESET_WORD = '{
        pcWrite: 1'b0, memRead: 1'b0, irWrite: 1'b1, regWrite: 1'b0,
        aluOutWrite: 1'b0, aluSrcA: SRCA_PC, aluSrcB: SRCB_REGB,
        regDst: 2'd1, addrSel: 3'd0, aluOp: ALU_PASS, pcSrc: PCSRC_ALU,
        writeDataSel: 4'd10
    };

endpackage

//--- verilog/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  isaPkg::opcode_e     opcode,
    input  isaPkg::funct_e      funct,
    output isaPkg::instrClass_e instrClass
);

    // all encodings live here, new opcodes go in the outer case
    always_comb begin
        instrClass = isaPkg::ICL_ILLEGAL;
        case (opcode)
            isaPkg::RTYPE: begin
                case (funct)
                    isaPkg::FN_ADD: begin
                        instrClass = isaPkg::ICL_ADD;
                    end
                    isaPkg::FN_SUB: begin
                        instrClass = isaPkg::ICL_SUB;
                    end
                    isaPkg::FN_AND: begin
                        instrClass = isaPkg::ICL_AND;
                    end
                    isaPkg::FN_SLT: begin
                        instrClass = isaPkg::ICL_SLT;
                    end
                    isaPkg::FN_JR: begin
                        instrClass = isaPkg::ICL_JR;
                    end
                    isaPkg::FN_BREAK: begin
                        instrClass = isaPkg::ICL_BREAK;
                    end
                    isaPkg::FN_RTE: begin
                        instrClass = isaPkg::ICL_RTE;
                    end
                    default: begin
                        instrClass = isaPkg::ICL_ILLEGAL;
                    end
                endcase
            end
            default: begin
                instrClass = isaPkg::ICL_ILLEGAL;
            end
        endcase
    end

endmodule

//--- verilog/phaseSequencer.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module phaseSequencer (
    input  logic                clk,
    input  logic                reset,
    input  isaPkg::instrClass_e instrClass,
    output ctrlPkg::phase_e     phase,
    output logic [`STEP_W-1:0]  step
);

    // last step index of each phase length
    localparam logic [`STEP_W-1:0] FETCH_LAST = `STEP_W'(`FETCH_STEPS - 1);
    localparam logic [`STEP_W-1:0] DECODE_LAST = `STEP_W'(`DECODE_STEPS - 1);
    localparam logic [`STEP_W-1:0] TWO_CYCLE_LAST = `STEP_W'(1);
    localparam logic [`STEP_W-1:0] ONE_CYCLE_LAST = `STEP_W'(0);

    typedef struct packed {
        ctrlPkg::phase_e          phase;
        logic [`STEP_W-1:0] step;
    } seqPos_t;

    seqPos_t                  pos;
    seqPos_t                  posNext;
    logic [`STEP_W-1:0] lastStep;
    ctrlPkg::phase_e          execPhase;

    always_comb begin
        case (pos.phase)
            ctrlPkg::PH_FETCH:  lastStep = FETCH_LAST;
            ctrlPkg::PH_DECODE: lastStep = DECODE_LAST;
            ctrlPkg::PH_ADD,
            ctrlPkg::PH_SUB,
            ctrlPkg::PH_AND,
            ctrlPkg::PH_SLT,
            ctrlPkg::PH_JR,
            ctrlPkg::PH_BREAK:  lastStep = TWO_CYCLE_LAST;
            default:            lastStep = ONE_CYCLE_LAST;
        endcase
    end

    // execute phase picked at dispatch, illegal goes straight back to fetch
    always_comb begin
        case (instrClass)
            isaPkg::ICL_ADD:   execPhase = ctrlPkg::PH_ADD;
            isaPkg::ICL_SUB:   execPhase = ctrlPkg::PH_SUB;
            isaPkg::ICL_AND:   execPhase = ctrlPkg::PH_AND;
            isaPkg::ICL_SLT:   execPhase = ctrlPkg::PH_SLT;
            isaPkg::ICL_JR:    execPhase = ctrlPkg::PH_JR;
            isaPkg::ICL_BREAK: execPhase = ctrlPkg::PH_BREAK;
            isaPkg::ICL_RTE:   execPhase = ctrlPkg::PH_RTE;
            default:           execPhase = ctrlPkg::PH_FETCH;
        endcase
    end

    always_comb begin
        posNext.phase = pos.phase;
        posNext.step = pos.step + `STEP_W'(1);
        if (pos.step == lastStep) begin
            posNext.step = '0;
            case (pos.phase)
                ctrlPkg::PH_FETCH:  posNext.phase = ctrlPkg::PH_IRLOAD;
                ctrlPkg::PH_IRLOAD: posNext.phase = ctrlPkg::PH_DECODE;
                // dispatch cycle
                ctrlPkg::PH_DECODE: posNext.phase = execPhase;
                default:            posNext.phase = ctrlPkg::PH_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pos.phase <= ctrlPkg::PH_FETCH;
            pos.step <= '0;
        end else begin
            pos <= posNext;
        end
    end

    assign phase = pos.phase;
    assign step = pos.step;

endmodule

//--- verilog/controlWordGen.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module controlWordGen (
    input  logic                clk,
    input  logic                reset,
    input  ctrlPkg::phase_e     phase,
    input  logic [`STEP_W-1:0]  step,
    input  isaPkg::instrClass_e instrClass,
    output ctrlPkg::ctrlWord_t  ctrl,
    output logic                rstOut
);

    ctrlPkg::aluOp_e    classOp;
    ctrlPkg::aluOp_e    execOp;
    ctrlPkg::ctrlWord_t word;

    always_comb begin
        case (instrClass)
            isaPkg::ICL_ADD: classOp = ctrlPkg::ALU_ADD;
            isaPkg::ICL_SUB: classOp = ctrlPkg::ALU_SUB;
            isaPkg::ICL_AND: classOp = ctrlPkg::ALU_AND;
            isaPkg::ICL_SLT: classOp = ctrlPkg::ALU_SLT;
            default:         classOp = ctrlPkg::ALU_PASS;
        endcase
    end

    // opcode may change after dispatch, so keep the op seen during decode
    always_ff @(posedge clk) begin
        if (phase == ctrlPkg::PH_DECODE) begin
            execOp <= classOp;
        end
    end

    always_comb begin
        word = ctrlPkg::IDLE_WORD;
        case (phase)
            ctrlPkg::PH_FETCH: begin
                // read instruction memory, compute pc + 4
                word.memRead = 1'b1;
                word.aluSrcB = ctrlPkg::SRCB_FOUR;
                word.aluOp = ctrlPkg::ALU_ADD;
            end
            ctrlPkg::PH_IRLOAD: begin
                word.pcWrite = 1'b1;
                word.irWrite = 1'b1;
            end
            ctrlPkg::PH_DECODE: begin
                if (step == '0) begin
                    // branch target while registers are read
                    word.aluSrcB = ctrlPkg::SRCB_FOUR;
                    word.aluOp = ctrlPkg::ALU_ADD;
                end else if (step == `STEP_W'(1)) begin
                    word.aluOutWrite = 1'b1;
                end
            end
            ctrlPkg::PH_ADD,
            ctrlPkg::PH_SUB,
            ctrlPkg::PH_AND,
            ctrlPkg::PH_SLT: begin
                if (step == '0) begin
                    word.aluSrcA = ctrlPkg::SRCA_REGA;
                    word.aluOp = execOp;
                end else begin
                    word.regWrite = 1'b1;
                    word.regDst = 2'd3;
                    // slt result comes through its own write mux input
                    word.writeDataSel = (phase == ctrlPkg::PH_SLT) ? 4'd9 : 4'd5;
                end
            end
            ctrlPkg::PH_JR: begin
                if (step == '0) begin
                    word.aluSrcA = ctrlPkg::SRCA_REGA;
                end else begin
                    word.pcWrite = 1'b1;
                    word.pcSrc = ctrlPkg::PCSRC_EPC;
                end
            end
            ctrlPkg::PH_BREAK: begin
                if (step == '0) begin
                    // pc - 4
                    word.aluOp = ctrlPkg::ALU_SUB;
                    word.aluSrcB = ctrlPkg::SRCB_FOUR;
                end else begin
                    word.pcWrite = 1'b1;
                    word.pcSrc = ctrlPkg::PCSRC_ALU;
                end
            end
            ctrlPkg::PH_RTE: begin
                word.pcWrite = 1'b1;
                word.pcSrc = ctrlPkg::PCSRC_EPC;
            end
            default: begin
                word = ctrlPkg::IDLE_WORD;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl <= ctrlPkg::RESET_WORD;
            rstOut <= 1'b1;
        end else begin
            ctrl <= word;
            rstOut <= 1'b0;
        end
    end

endmodule

//--- verilog/controlUnit.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module controlUnit (
    input  logic               clk,
    input  logic               reset,
    input  isaPkg::opcode_e    opcode,
    input  isaPkg::funct_e     funct,
    output ctrlPkg::ctrlWord_t ctrl,
    output logic               rstOut
);

    isaPkg::instrClass_e instrClass;
    ctrlPkg::phase_e     phase;
    logic [`STEP_W-1:0]  step;

    instrDecoder decoder (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    phaseSequencer sequencer (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .phase      (phase),
        .step       (step)
    );

    // word lags phase and step by one edge
    controlWordGen wordGen (
        .clk        (clk),
        .reset      (reset),
        .phase      (phase),
        .step       (step),
        .instrClass (instrClass),
        .ctrl       (ctrl),
        .rstOut     (rstOut)
    );

endmodule

//--- tests/controlUnit_asserts.sv
`timescale 1ns/1ps

module controlUnit_asserts (
    input logic               clk,
    input logic               reset,
    input ctrlPkg::phase_e    phase,
    input ctrlPkg::ctrlWord_t ctrl,
    input logic               rstOut
);

    // failures seen so far, read by the testbench
    int errCount = 0;

    // pc and register file never written by the same word
    noDoubleWrite: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.pcWrite && ctrl.regWrite))
    else begin
        errCount++;
        $error("pcWrite and regWrite set in the same word");
    end

    // ctrl lags phase by one edge
    memReadInFetch: assert property (@(posedge clk) disable iff (reset)
        ctrl.memRead |-> $past(phase) == ctrlPkg::PH_FETCH)
    else begin
        errCount++;
        $error("memRead set outside fetch");
    end

    rstOutLow: assert property (@(posedge clk)
        $fell(reset) |=> !rstOut)
    else begin
        errCount++;
        $error("rstOut still high one cycle after reset fell");
    end

endmodule

bind controlWordGen controlUnit_asserts asserts (
    .clk    (clk),
    .reset  (reset),
    .phase  (phase),
    .ctrl   (ctrl),
    .rstOut (rstOut)
);

//--- tests/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 10;
    localparam int RANDOM_ENTRIES = 20;
    localparam int FIXED_CYCLES = 7;
    localparam int WATCHDOG_SLACK = 50;

    // one instruction and the words its execute cycles must show
    typedef struct packed {
        isaPkg::opcode_e          opcode;
        isaPkg::funct_e           funct;
        ctrlPkg::ctrlWord_t [1:0] execWords;
        logic [3:0]               length;
    } entry_t;

    logic               clk;
    logic               reset;
    isaPkg::opcode_e    opcode;
    isaPkg::funct_e     funct;
    ctrlPkg::ctrlWord_t ctrl;
    logic               rstOut;

    entry_t entries[$];
    string  entryNames[$];
    bit     tableReady = 1'b0;
    int     totalCycles = 0;

    controlUnit uut (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .funct  (funct),
        .ctrl   (ctrl),
        .rstOut (rstOut)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abortRun(string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic checkWord(string name, ctrlPkg::ctrlWord_t expected,
                             ctrlPkg::ctrlWord_t actual);
        if (actual !== expected) begin
            $display("error %s expected %h actual %h", name, expected, actual);
            abortRun("control word mismatch");
        end
    endtask

    task automatic checkFlag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("error %s expected %b actual %b", name, expected, actual);
            abortRun("flag mismatch");
        end
    endtask

    task automatic checkAsserts(string name);
        if (uut.wordGen.asserts.errCount != 0) begin
            abortRun($sformatf("bound assertion failed during %s", name));
        end
    endtask

    function automatic ctrlPkg::ctrlWord_t resetWord();
        ctrlPkg::ctrlWord_t w;
        w = '0;
        w.irWrite = 1'b1;
        w.regDst = 2'd1;
        w.writeDataSel = 4'd10;
        return w;
    endfunction

    // fetch, ir load and decode words shared by every instruction
    function automatic ctrlPkg::ctrlWord_t fixedWord(int pos);
        ctrlPkg::ctrlWord_t w;
        w = '0;
        if (pos < 3) begin
            w.memRead = 1'b1;
            w.aluSrcB = ctrlPkg::SRCB_FOUR;
            w.aluOp = ctrlPkg::ALU_ADD;
        end else if (pos == 3) begin
            w.pcWrite = 1'b1;
            w.irWrite = 1'b1;
        end else if (pos == 4) begin
            w.aluSrcB = ctrlPkg::SRCB_FOUR;
            w.aluOp = ctrlPkg::ALU_ADD;
        end else if (pos == 5) begin
            w.aluOutWrite = 1'b1;
        end
        return w;
    endfunction

    function automatic ctrlPkg::ctrlWord_t execWord(isaPkg::instrClass_e cls, int idx);
        ctrlPkg::ctrlWord_t w;
        w = '0;
        case (cls)
            isaPkg::ICL_ADD, isaPkg::ICL_SUB, isaPkg::ICL_AND, isaPkg::ICL_SLT: begin
                if (idx == 0) begin
                    w.aluSrcA = ctrlPkg::SRCA_REGA;
                    case (cls)
                        isaPkg::ICL_ADD: w.aluOp = ctrlPkg::ALU_ADD;
                        isaPkg::ICL_SUB: w.aluOp = ctrlPkg::ALU_SUB;
                        isaPkg::ICL_AND: w.aluOp = ctrlPkg::ALU_AND;
                        default:         w.aluOp = ctrlPkg::ALU_SLT;
                    endcase
                end else begin
                    w.regWrite = 1'b1;
                    w.regDst = 2'd3;
                    w.writeDataSel = (cls == isaPkg::ICL_SLT) ? 4'd9 : 4'd5;
                end
            end
            isaPkg::ICL_JR: begin
                if (idx == 0) begin
                    w.aluSrcA = ctrlPkg::SRCA_REGA;
                end else begin
                    w.pcWrite = 1'b1;
                    w.pcSrc = ctrlPkg::PCSRC_EPC;
                end
            end
            isaPkg::ICL_BREAK: begin
                if (idx == 0) begin
                    w.aluOp = ctrlPkg::ALU_SUB;
                    w.aluSrcB = ctrlPkg::SRCB_FOUR;
                end else begin
                    w.pcWrite = 1'b1;
                    w.pcSrc = ctrlPkg::PCSRC_ALU;
                end
            end
            isaPkg::ICL_RTE: begin
                if (idx == 0) begin
                    w.pcWrite = 1'b1;
                    w.pcSrc = ctrlPkg::PCSRC_EPC;
                end
            end
            default: begin
                w = '0;
            end
        endcase
        return w;
    endfunction

    function automatic int execLength(isaPkg::instrClass_e cls);
        case (cls)
            isaPkg::ICL_RTE:     return 1;
            isaPkg::ICL_ILLEGAL: return 0;
            default:             return 2;
        endcase
    endfunction

    task automatic addEntry(string name, isaPkg::opcode_e op, isaPkg::funct_e fn,
                            isaPkg::instrClass_e cls);
        entry_t e;
        e.opcode = op;
        e.funct = fn;
        e.execWords[0] = execWord(cls, 0);
        e.execWords[1] = execWord(cls, 1);
        e.length = 4'(FIXED_CYCLES + execLength(cls));
        entries.push_back(e);
        entryNames.push_back(name);
        totalCycles += FIXED_CYCLES + execLength(cls);
    endtask

    // k picks one of the seven decoded instructions
    task automatic addKept(string name, int k);
        case (k)
            0: addEntry(name, isaPkg::RTYPE, isaPkg::FN_ADD, isaPkg::ICL_ADD);
            1: addEntry(name, isaPkg::RTYPE, isaPkg::FN_SUB, isaPkg::ICL_SUB);
            2: addEntry(name, isaPkg::RTYPE, isaPkg::FN_AND, isaPkg::ICL_AND);
            3: addEntry(name, isaPkg::RTYPE, isaPkg::FN_SLT, isaPkg::ICL_SLT);
            4: addEntry(name, isaPkg::RTYPE, isaPkg::FN_JR, isaPkg::ICL_JR);
            5: addEntry(name, isaPkg::RTYPE, isaPkg::FN_BREAK, isaPkg::ICL_BREAK);
            default: addEntry(name, isaPkg::RTYPE, isaPkg::FN_RTE, isaPkg::ICL_RTE);
        endcase
    endtask

    task automatic buildTable();
        addKept("add", 0);
        addKept("sub", 1);
        addKept("and", 2);
        addKept("slt", 3);
        addKept("jr", 4);
        addKept("break", 5);
        addKept("rte", 6);
        // addu funct is not decoded
        addEntry("bad funct", isaPkg::RTYPE, isaPkg::funct_e'(6'd33), isaPkg::ICL_ILLEGAL);
        // lw opcode
        addEntry("non-R opcode", isaPkg::opcode_e'(6'd35), isaPkg::FN_ADD,
                 isaPkg::ICL_ILLEGAL);
        for (int i = 0; i < RANDOM_ENTRIES; i++) begin
            addKept($sformatf("random %0d", i), int'($urandom % 7));
        end
    endtask

    initial begin : watchdog
        wait (tableReady);
        repeat (totalCycles + RESET_CYCLES + WATCHDOG_SLACK) @(posedge clk);
        abortRun("timeout, the instruction table did not finish in time");
    end

    initial begin
        int                 pos;
        entry_t             e;
        ctrlPkg::ctrlWord_t expected;
        reset = 1'b1;
        opcode = isaPkg::RTYPE;
        funct = isaPkg::FN_ADD;
        void'($urandom(32'hc6f7_5070));
        buildTable();
        tableReady = 1'b1;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            checkWord("reset ctrl", resetWord(), ctrl);
            checkFlag("reset rstOut", 1'b1, rstOut);
        end
        reset = 1'b0;
        opcode = entries[0].opcode;
        funct = entries[0].funct;

        for (int i = 0; i < entries.size(); i++) begin
            e = entries[i];
            for (pos = 0; pos < int'(e.length); pos++) begin
                @(negedge clk);
                if (pos < FIXED_CYCLES) begin
                    expected = fixedWord(pos);
                end else begin
                    expected = e.execWords[pos - FIXED_CYCLES];
                end
                checkWord($sformatf("%s cycle %0d ctrl", entryNames[i], pos), expected, ctrl);
                checkFlag($sformatf("%s cycle %0d rstOut", entryNames[i], pos), 1'b0, rstOut);
                checkAsserts(entryNames[i]);
            end
            // dut sits in its first fetch cycle now
            if (i + 1 < entries.size()) begin
                opcode = entries[i + 1].opcode;
                funct = entries[i + 1].funct;
            end
        end

        if (uut.wordGen.asserts.errCount == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            abortRun("a bound assertion failed");
        end
    end

endmodule

//--- tb.f
+incdir+verilog
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/instrDecoder.sv
verilog/phaseSequencer.sv
verilog/controlWordGen.sv
verilog/controlUnit.sv
tests/controlUnit_asserts.sv
tests/controlUnitTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module controlUnitTb -f tb.f -o controlUnitSim

# the log decides the result, not the exit status of the pipe
./obj_dir/controlUnitSim 2>&1 | tee sim.log

if grep -qx "sim passed" sim.log; then
    echo "simulation ok"
else
    echo "simulation reported failure"
    exit 1
fi
